/* chan_est.f */
+incdir+.
chan_est_pkg.sv
error_window.sv
channel_estimator.sv
tap_readout.sv
chan_est_top.sv
chan_est_properties.sv
chan_est_tb.sv

/* chan_est_params.svh */
`ifndef CHAN_EST_PARAMS_SVH
`define CHAN_EST_PARAMS_SVH

// Lane and tap geometry.
`define CE_LANES      4
`define CE_EST_DEPTH  30
`define CE_ERR_DEPTH  32

// Datapath widths.
`define CE_EST_W      8
`define CE_ADAPT_W    16
`define CE_ERR_W      9

// Index and control widths.
`define CE_TAP_ADDR_W 5
`define CE_LANE_W     2
`define CE_GAIN_W     4
`define CE_INST_W     3

`endif

/* chan_est_pkg.sv */
`include "chan_est_params.svh"

package chan_est_pkg;

    typedef logic signed [`CE_ERR_W-1:0]             err_t;
    typedef logic signed [`CE_EST_W-1:0]             tap_t;
    typedef logic signed [`CE_EST_W:0]               load_val_t;
    typedef logic signed [`CE_EST_W+`CE_ADAPT_W-1:0] acc_t;   // Tap value with fraction bits.
    typedef logic [`CE_TAP_ADDR_W-1:0]               tap_addr_t;
    typedef logic [`CE_LANE_W-1:0]                   lane_t;
    typedef logic [`CE_LANES-1:0]                    lane_mask_t;
    typedef logic [`CE_GAIN_W-1:0]                   gain_t;

    // Code 100 selects a direct tap load.
    typedef enum logic [`CE_INST_W-1:0] {
        INST_HALT = 3'b000,
        INST_LOAD = 3'b100
    } inst_e;

    typedef enum logic [2:0] {
        RST,
        LOAD_AND_CALC,
        CALC_AND_STORE,
        EXEC,
        HALT
    } est_state_e;

    typedef struct packed {
        logic      exec_inst;
        inst_e     inst;
        load_val_t load_val;
        tap_addr_t load_addr;
    } lane_cmd_s;

    // Entry 0 holds the newest error.
    typedef struct packed {
        err_t [`CE_ERR_DEPTH-1:0] err;
        logic                     current_bit;
    } err_window_s;

endpackage

/* chan_est_properties.sv */
`include "chan_est_params.svh"

module chan_est_properties import chan_est_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      peak_start,
    input logic      peak_done,
    input tap_t      rd_data
);

    int unsigned fail_count;

    initial begin
        fail_count = 0;
    end

    // Readout outputs are clear one cycle into reset.
    reset_clear_a: assert property (@(posedge clk) !rst_n |=> (!peak_done && rd_data == '0))
        else begin
            $error("readout outputs not cleared by reset");
            fail_count++;
        end

    read_known_a: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(rd_data))
        else begin
            $error("rd_data unknown after reset");
            fail_count++;
        end

    // The host only starts a search while none is running.
    peak_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        peak_start |=> !peak_done [* `CE_EST_DEPTH] ##1 peak_done)
        else begin
            $error("peak_done not exactly one scan after peak_start");
            fail_count++;
        end

endmodule

bind chan_est_top chan_est_properties props (
    .clk        (clk),
    .rst_n      (rst_n),
    .peak_start (peak_start),
    .peak_done  (peak_done),
    .rd_data    (rd_data)
);

/* chan_est_tb.sv */
`include "chan_est_params.svh"

module chan_est_tb import chan_est_pkg::*; ();

    localparam int LOADS      = 8;
    localparam int MAX_SWEEPS = 6;
    localparam int PEAK_WAIT  = 2 * `CE_EST_DEPTH;

    logic                 clk;
    logic                 rst_n;
    logic                 err_strobe;
    err_t [`CE_LANES-1:0] err_in;
    lane_mask_t           bit_in;
    lane_cmd_s            host_cmd;
    lane_mask_t           host_lane_mask;
    gain_t                gain;
    lane_t                rd_lane;
    tap_addr_t            rd_addr;
    logic                 peak_start;
    lane_t                peak_lane;
    tap_t                 rd_data;
    logic                 peak_done;
    tap_addr_t            peak_addr;
    tap_t                 peak_val;
    tap_t                 model [`CE_LANES][`CE_EST_DEPTH];   // Expected visible taps.
    tap_t                 prev_tap [`CE_EST_DEPTH];

    chan_est_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Error: time %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    always @(negedge clk) begin
        if (dut0.props.fail_count != 0) begin
            $display("A timing property of the bound checker failed");
            stop_with_failure();
        end
    end

    function automatic tap_t random_tap();
        return tap_t'(int'($urandom_range(200)) - 100);
    endfunction

    task automatic read_tap(input lane_t lane, input tap_addr_t addr, output tap_t value);
        @(posedge clk);
        rd_lane <= lane;
        rd_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        value = rd_data;
    endtask

    task automatic check_lanes(input int first, input int last);
        tap_t value;
        for (int l = first; l <= last; l++) begin
            for (int a = 0; a < `CE_EST_DEPTH; a++) begin
                read_tap(lane_t'(l), tap_addr_t'(a), value);
                assert (value == model[l][a])
                    else report_error($sformatf("lane %0d tap %0d reads %0d, expected %0d",
                                                l, a, value, model[l][a]));
                assert (!peak_done) else report_error("peak_done high with no search");
            end
        end
    endtask

    // The command is left asserted, so the lane parks in HALT after the write.
    task automatic load_tap(input lane_t lane, input tap_addr_t addr, input tap_t value);
        lane_cmd_s c;
        c.exec_inst = 1'b1;
        c.inst      = INST_LOAD;
        c.load_val  = load_val_t'(value);
        c.load_addr = addr;
        @(posedge clk);
        host_cmd       <= c;
        host_lane_mask <= lane_mask_t'(1) << lane;
        rd_lane        <= lane;
        rd_addr        <= addr;
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (rd_data == value)
            else report_error($sformatf("load of lane %0d tap %0d reads %0d, expected %0d",
                                        lane, addr, rd_data, value));
        model[lane][addr] = value;
    endtask

    task automatic release_cmd();
        @(posedge clk);
        host_cmd       <= '0;
        host_lane_mask <= '0;
        repeat (3) @(posedge clk);
    endtask

    task automatic push_errors(input err_t err0, input logic bit0, input int count);
        err_t [`CE_LANES-1:0] errs;
        errs    = '0;
        errs[0] = err0;
        for (int n = 0; n < count; n++) begin
            @(posedge clk);
            err_strobe <= 1'b1;
            err_in     <= errs;
            bit_in     <= lane_mask_t'(bit0);
        end
        @(posedge clk);
        err_strobe <= 1'b0;
    endtask

    // A sweep spans one full walk, so each lane 0 tap moves by exactly one step.
    task automatic track_adaptation(input int dir);
        tap_t value;
        tap_t start0;
        int   delta;
        int   sweeps;
        for (int a = 0; a < `CE_EST_DEPTH; a++) begin
            read_tap('0, tap_addr_t'(a), prev_tap[a]);
        end
        start0 = prev_tap[0];
        sweeps = 0;
        while ((int'(prev_tap[0]) - int'(start0)) * dir <= 0) begin
            if (sweeps == MAX_SWEEPS) begin
                $display("Tap 0 of lane 0 did not adapt within the sweep limit");
                stop_with_failure();
            end
            for (int a = 0; a < `CE_EST_DEPTH; a++) begin
                read_tap('0, tap_addr_t'(a), value);
                delta = int'(value) - int'(prev_tap[a]);
                assert (delta == dir)
                    else report_error($sformatf("lane 0 tap %0d moved by %0d, expected %0d",
                                                a, delta, dir));
                prev_tap[a] = value;
            end
            sweeps++;
        end
    endtask

    initial begin
        lane_t     lane;
        tap_t      value;
        tap_t      best_val;
        tap_addr_t best_addr;
        bit        used [256];
        int        waited;
        int        mag;
        int        best_mag;

        void'($urandom(17812));
        rst_n          = 1'b0;
        err_strobe     = 1'b0;
        err_in         = '0;
        bit_in         = '0;
        host_cmd       = '0;
        host_lane_mask = '0;
        gain           = '0;
        rd_lane        = '0;
        rd_addr        = '0;
        peak_start     = 1'b0;
        peak_lane      = '0;
        for (int l = 0; l < `CE_LANES; l++) begin
            for (int a = 0; a < `CE_EST_DEPTH; a++) begin
                model[l][a] = '0;
            end
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        check_lanes(0, `CE_LANES - 1);

        for (int n = 0; n < LOADS; n++) begin
            lane = lane_t'($urandom_range(`CE_LANES - 1));
            load_tap(lane, tap_addr_t'($urandom_range(`CE_EST_DEPTH - 1)), random_tap());
            release_cmd();
        end
        check_lanes(0, `CE_LANES - 1);

        // Taps hold while the load instruction stays asserted.
        lane = lane_t'($urandom_range(`CE_LANES - 1));
        load_tap(lane, tap_addr_t'($urandom_range(`CE_EST_DEPTH - 1)), random_tap());
        check_lanes(lane, lane);
        check_lanes(lane, lane);
        release_cmd();
        check_lanes(0, `CE_LANES - 1);

        // Gain 15 with unit error makes one visit worth one visible step.
        @(posedge clk);
        gain <= 4'd15;
        push_errors(9'sd1, 1'b0, `CE_ERR_DEPTH);
        track_adaptation(1);
        push_errors(9'sd1, 1'b1, 1);
        repeat (3) @(posedge clk);
        track_adaptation(-1);
        @(posedge clk);
        gain <= '0;
        push_errors('0, 1'b0, `CE_ERR_DEPTH);

        lane = lane_t'($urandom_range(`CE_LANES - 1));
        for (int v = 0; v < 256; v++) begin
            used[v] = 1'b0;
        end
        best_mag = -1;
        for (int a = 0; a < `CE_EST_DEPTH; a++) begin
            do begin
                value = random_tap();
            end while (used[int'(value) + 128]);
            used[int'(value) + 128] = 1'b1;
            load_tap(lane, tap_addr_t'(a), value);
            release_cmd();
            mag = (value < 0) ? -int'(value) : int'(value);
            if (mag > best_mag) begin                  // Ties keep the lower index.
                best_mag  = mag;
                best_addr = tap_addr_t'(a);
                best_val  = value;
            end
        end
        @(posedge clk);
        peak_start <= 1'b1;
        peak_lane  <= lane;
        @(posedge clk);
        peak_start <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!peak_done) begin
            if (waited == PEAK_WAIT) begin
                $display("No peak_done arrived after the peak search started");
                stop_with_failure();
            end
            @(negedge clk);
            waited++;
        end
        assert (peak_addr == best_addr && peak_val == best_val)
            else report_error($sformatf("peak at tap %0d value %0d, expected tap %0d value %0d",
                                        peak_addr, peak_val, best_addr, best_val));

        repeat (3) @(posedge clk);
        if (dut0.props.fail_count != 0) begin
            $display("A timing property of the bound checker failed");
            stop_with_failure();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* chan_est_top.sv */
`include "chan_est_params.svh"

module chan_est_top import chan_est_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          err_strobe,
    input  err_t [`CE_LANES-1:0]          err_in,
    input  lane_mask_t                    bit_in,
    input  lane_cmd_s                     host_cmd,
    input  lane_mask_t                    host_lane_mask,
    input  gain_t                         gain,
    input  lane_t                         rd_lane,
    input  tap_addr_t                     rd_addr,
    input  logic                          peak_start,
    input  lane_t                         peak_lane,
    output tap_t                          rd_data,
    output logic                          peak_done,
    output tap_addr_t                     peak_addr,
    output tap_t                          peak_val
);

    err_window_s [`CE_LANES-1:0]                  lane_window;
    lane_cmd_s   [`CE_LANES-1:0]                  lane_cmd;
    tap_t        [`CE_LANES-1:0][`CE_EST_DEPTH-1:0] lane_taps;

    error_window feeder (
        .clk            (clk),
        .rst_n          (rst_n),
        .err_strobe     (err_strobe),
        .err_in         (err_in),
        .bit_in         (bit_in),
        .host_cmd       (host_cmd),
        .host_lane_mask (host_lane_mask),
        .window         (lane_window),
        .cmd            (lane_cmd)
    );

    for (genvar i = 0; i < `CE_LANES; i++) begin : lane_g
        channel_estimator est (
            .clk      (clk),
            .rst_n    (rst_n),
            .window   (lane_window[i]),
            .cmd      (lane_cmd[i]),
            .gain     (gain),
            .est_chan (lane_taps[i])
        );
    end

    tap_readout readout (
        .clk        (clk),
        .rst_n      (rst_n),
        .taps       (lane_taps),
        .rd_lane    (rd_lane),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .peak_start (peak_start),
        .peak_lane  (peak_lane),
        .peak_done  (peak_done),
        .peak_addr  (peak_addr),
        .peak_val   (peak_val)
    );

endmodule

/* channel_estimator.sv */
`include "chan_est_params.svh"

module channel_estimator import chan_est_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    input  err_window_s                     window,
    input  lane_cmd_s                       cmd,
    input  gain_t                           gain,
    output tap_t [`CE_EST_DEPTH-1:0]        est_chan
);

    acc_t       acc [`CE_EST_DEPTH];
    acc_t       tap_sum;
    acc_t       next_tap_sum;
    acc_t       err_ext;
    acc_t       step;
    acc_t       adjust;
    acc_t       load_acc;
    err_t       tap_err;
    load_val_t  load_val;
    tap_addr_t  tap_pos;
    tap_addr_t  next_tap_pos;
    est_state_e state;
    est_state_e next_state;
    logic       store;
    logic       load;

    // The sign-data update uses the error at this tap, negated when the decided bit is one.
    assign tap_err = window.err[tap_pos];
    assign err_ext = tap_err;                      // Sign extends into the accumulator width.
    assign step    = err_ext <<< gain;
    assign adjust  = window.current_bit ? -step : step;

    assign load_val = cmd.load_val;
    assign load_acc = acc_t'(load_val) <<< `CE_ADAPT_W;

    // The write lands on the edge that enters EXEC, so a load costs one cycle here.
    assign load = (next_state == EXEC) && (cmd.inst == INST_LOAD) &&
                  (cmd.load_addr < `CE_EST_DEPTH);

    always_comb begin
        for (int i = 0; i < `CE_EST_DEPTH; i++) begin
            est_chan[i] = tap_t'(acc[i] >>> `CE_ADAPT_W);
        end
    end

    always_comb begin
        next_state   = state;
        next_tap_pos = tap_pos;
        next_tap_sum = tap_sum;
        store        = 1'b0;
        case (state)
            RST: begin
                next_tap_pos = '0;
                next_state   = cmd.exec_inst ? EXEC : LOAD_AND_CALC;
            end
            LOAD_AND_CALC: begin
                next_tap_sum = acc[tap_pos] + adjust;   // First half of the double step.
                next_state   = cmd.exec_inst ? EXEC : CALC_AND_STORE;
            end
            CALC_AND_STORE: begin
                next_tap_sum = tap_sum + adjust;
                store        = 1'b1;
                if (tap_pos == `CE_EST_DEPTH - 1) begin
                    next_tap_pos = '0;
                end else begin
                    next_tap_pos = tap_pos + 1'b1;
                end
                next_state = cmd.exec_inst ? EXEC : LOAD_AND_CALC;
            end
            EXEC: begin
                next_tap_pos = '0;
                next_tap_sum = '0;
                next_state   = HALT;
            end
            HALT: begin
                next_tap_pos = '0;
                next_tap_sum = '0;
                next_state   = cmd.exec_inst ? HALT : LOAD_AND_CALC;   // Restart at tap 0.
            end
            default: begin
                next_tap_pos = '0;
                next_tap_sum = '0;
                next_state   = RST;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= RST;
            tap_pos <= '0;
            tap_sum <= '0;
        end else begin
            state   <= next_state;
            tap_pos <= next_tap_pos;
            tap_sum <= next_tap_sum;
        end
    end

    // A load to the tap being stored wins over the adaptation result.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CE_EST_DEPTH; i++) begin
                acc[i] <= '0;
            end
        end else begin
            if (store) begin
                acc[tap_pos] <= next_tap_sum;
            end
            if (load) begin
                acc[cmd.load_addr] <= load_acc;
            end
        end
    end

endmodule

/* error_window.sv */
`include "chan_est_params.svh"

module error_window import chan_est_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          err_strobe,
    input  err_t        [`CE_LANES-1:0]   err_in,
    input  lane_mask_t                    bit_in,
    input  lane_cmd_s                     host_cmd,
    input  lane_mask_t                    host_lane_mask,
    output err_window_s [`CE_LANES-1:0]   window,
    output lane_cmd_s   [`CE_LANES-1:0]   cmd
);

    err_window_s [`CE_LANES-1:0] next_window;
    lane_cmd_s   [`CE_LANES-1:0] next_cmd;

    // Each lane shifts its own window on the common strobe.
    always_comb begin
        for (int i = 0; i < `CE_LANES; i++) begin
            next_window[i] = window[i];
            if (err_strobe) begin
                next_window[i].err         = {window[i].err[`CE_ERR_DEPTH-2:0], err_in[i]};
                next_window[i].current_bit = bit_in[i];
            end
        end
    end

    // Unselected lanes see an all-zero command, which lets them keep adapting.
    always_comb begin
        for (int i = 0; i < `CE_LANES; i++) begin
            if (host_lane_mask[i]) begin
                next_cmd[i] = host_cmd;
            end else begin
                next_cmd[i] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window <= '0;
        end else begin
            window <= next_window;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd <= '0;
        end else begin
            cmd <= next_cmd;
        end
    end

endmodule

/* tap_readout.sv */
`include "chan_est_params.svh"

module tap_readout import chan_est_pkg::*; (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  tap_t [`CE_LANES-1:0][`CE_EST_DEPTH-1:0]    taps,
    input  lane_t                                      rd_lane,
    input  tap_addr_t                                  rd_addr,
    output tap_t                                       rd_data,
    input  logic                                       peak_start,
    input  lane_t                                      peak_lane,
    output logic                                       peak_done,
    output tap_addr_t                                  peak_addr,
    output tap_t                                       peak_val
);

    // Magnitude needs one extra bit so that the most negative tap fits.
    function automatic logic [`CE_EST_W:0] tap_mag(input tap_t t);
        logic [`CE_EST_W:0] wide;
        wide = {t[`CE_EST_W-1], t};
        return t[`CE_EST_W-1] ? -wide : wide;
    endfunction

    logic               scan_busy;
    lane_t              scan_lane;
    tap_addr_t          scan_idx;
    tap_addr_t          best_addr;
    tap_t               best_val;
    logic [`CE_EST_W:0] best_mag;
    tap_t               cur_val;
    logic [`CE_EST_W:0] cur_mag;
    logic               take;
    logic               last;

    assign cur_val = taps[scan_lane][scan_idx];
    assign cur_mag = tap_mag(cur_val);
    assign take    = (scan_idx == '0) || (cur_mag > best_mag);   // Ties keep the lower index.
    assign last    = (scan_idx == `CE_EST_DEPTH - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data   <= '0;
            scan_busy <= 1'b0;
            scan_lane <= '0;
            scan_idx  <= '0;
            peak_done <= 1'b0;
            peak_addr <= '0;
            peak_val  <= '0;
        end else begin
            rd_data   <= (rd_addr < `CE_EST_DEPTH) ? taps[rd_lane][rd_addr] : '0;
            peak_done <= 1'b0;
            if (!scan_busy) begin
                if (peak_start) begin
                    scan_busy <= 1'b1;
                    scan_lane <= peak_lane;
                    scan_idx  <= '0;
                end
            end else if (last) begin
                scan_busy <= 1'b0;
                scan_idx  <= '0;
                peak_done <= 1'b1;
                peak_addr <= take ? scan_idx : best_addr;
                peak_val  <= take ? cur_val : best_val;
            end else begin
                scan_idx <= scan_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan_busy && take) begin
            best_addr <= scan_idx;
            best_val  <= cur_val;
            best_mag  <= cur_mag;
        end
    end

endmodule
